//--- bench/flash_patterns.txt
# kind opcode address write_value preset expected, all hex
# kind 0..6 = wren wrdi rdsr wrsr se pp read; expected is the first read byte, status or prog byte
0 06 000000 0000 00 0000
1 04 000000 0000 00 0000
2 05 000000 0000 5a 005a
2 05 000000 0000 c3 00c3
3 01 000000 a55a 00 a55a
3 01 000000 0281 00 0281
4 20 012000 0000 00 0000
4 20 fff000 0000 00 0000
5 02 003400 00e7 00 00e7
5 02 a5a5a5 003c 00 003c
6 03 000100 0000 10 0010
6 03 7ffffe 0000 fe 00fe
0 06 000000 0000 00 0000
2 05 000000 0000 80 0080
6 03 123456 0000 a0 00a0
1 04 000000 0000 00 0000
5 02 800001 0081 00 0081
3 01 000000 ffff 00 ffff

//--- compile.f
logic/flash_pkg.sv
logic/flash_tx_shifter.sv
logic/flash_cmd_seq.sv
logic/flash_rx_deser.sv
logic/flash_driver.sv
bench/flash_model.sv
bench/tb_flash_driver.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the flash driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f compile.f --top-module tb_flash_driver -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- bench/tb_flash_driver.sv
`default_nettype none

module tb_flash_driver
	import flash_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int READ_BYTES = 4;
	localparam int PROG_BYTES = 2;
	localparam int TIMEOUT    = 2000;        // clocks per wait loop
	localparam int RAND_RUNS  = 6;

	logic        I_clk_25M;
	logic        I_rst_n;
	logic        cmd_req;
	cmd_kind_e   cmd_kind;
	addr_t       cmd_addr;
	status_t     status_wr;
	byte_t       prog_data;
	logic        cmd_ack;
	byte_t       read_data;
	logic        read_valid;
	logic        flash_sclk;
	logic        flash_cs_n;
	logic        flash_io0;
	logic        flash_io1;
	byte_t       model_preset;
	byte_t       model_op;
	addr_t       model_addr;
	logic [63:0] model_wdata;
	int          model_frames;
	int          sclk_pulses = 0;
	int          idle_pulses;
	int          seed;
	int          pick;
	int          n;

	// one entry per pattern line
	cmd_kind_e pat_kind[$];
	byte_t     pat_op[$];
	addr_t     pat_addr[$];
	status_t   pat_wval[$];
	byte_t     pat_preset[$];
	status_t   pat_expect[$];

	always #20 I_clk_25M = ~I_clk_25M;

	always @(posedge flash_sclk)
		sclk_pulses = sclk_pulses + 1;

	flash_driver #(
		.READ_BYTES (READ_BYTES),
		.PROG_BYTES (PROG_BYTES)
	) u_flash_driver (
		.I_clk_25M  (I_clk_25M),
		.I_rst_n    (I_rst_n),
		.cmd_req    (cmd_req),
		.cmd_kind   (cmd_kind),
		.cmd_addr   (cmd_addr),
		.status_wr  (status_wr),
		.prog_data  (prog_data),
		.cmd_ack    (cmd_ack),
		.read_data  (read_data),
		.read_valid (read_valid),
		.flash_sclk (flash_sclk),
		.flash_cs_n (flash_cs_n),
		.flash_io0  (flash_io0),
		.flash_io1  (flash_io1)
	);

	flash_model u_flash_model (
		.sclk   (flash_sclk),
		.cs_n   (flash_cs_n),
		.io0    (flash_io0),
		.preset (model_preset),
		.io1    (flash_io1),
		.op     (model_op),
		.addr   (model_addr),
		.wdata  (model_wdata),
		.frames (model_frames)
	);

	////////////////////////////////////////
	// error exits and compare tasks
	////////////////////////////////////////
	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t want);
		if (got !== want)
		begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t want);
		if (got !== want)
		begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t want);
		if (got !== want)
		begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got !== want)
		begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_kind_code(input cmd_kind_e kind, input byte_t seen, input byte_t want);
		if (seen !== want)
		begin
			$display("MISMATCH model_op (%s): expected 0x%h, got 0x%h", kind.name(), want, seen);
			abort_run();
		end
	endtask

	task automatic load_patterns();
		int         fd;
		int         cnt;
		string      line;
		logic [2:0] kind;
		byte_t      op;
		addr_t      addr;
		status_t    wval;
		byte_t      pre;
		status_t    exp_val;
		fd = $fopen("bench/flash_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open bench/flash_patterns.txt");
			abort_run();
		end
		while (!$feof(fd))
		begin
			cnt = $fgets(line, fd);
			if (cnt > 0 && line[0] != "#")               // skip column notes
			begin
				cnt = $sscanf(line, "%h %h %h %h %h %h", kind, op, addr, wval, pre, exp_val);
				if (cnt == 6)
				begin
					pat_kind.push_back(cmd_kind_e'(kind));
					pat_op.push_back(op);
					pat_addr.push_back(addr);
					pat_wval.push_back(wval);
					pat_preset.push_back(pre);
					pat_expect.push_back(exp_val);
				end
			end
		end
		$fclose(fd);
		if (pat_kind.size() == 0)
		begin
			$display("pattern file holds no command lines");
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// one command with full handshake
	////////////////////////////////////////
	task automatic run_command(input int idx);
		cmd_kind_e kind;
		status_t   wval;
		status_t   exp_val;
		int        frames_before;
		int        pulses_before;
		int        reads;
		int        want_reads;
		int        want_pulses;
		int        waited;
		int        i;
		logic      ack_seen;
		kind          = pat_kind[idx];
		wval          = pat_wval[idx];
		exp_val       = pat_expect[idx];
		frames_before = model_frames;
		pulses_before = sclk_pulses;
		reads         = 0;
		want_reads    = 0;
		case (kind)
			CMD_RDSR:
			begin
				want_reads  = 1;
				want_pulses = BYTE_W + BYTE_W;
			end
			CMD_WRSR: want_pulses = BYTE_W + STATUS_W;
			CMD_SE:   want_pulses = BYTE_W + ADDR_W;
			CMD_PP:   want_pulses = BYTE_W + ADDR_W + BYTE_W * PROG_BYTES;
			CMD_READ:
			begin
				want_reads  = READ_BYTES;
				want_pulses = BYTE_W + ADDR_W + BYTE_W * READ_BYTES;
			end
			default:  want_pulses = BYTE_W;          // opcode only
		endcase

		cmd_kind     <= kind;
		cmd_addr     <= pat_addr[idx];
		status_wr    <= wval;
		prog_data    <= wval[BYTE_W-1:0];
		model_preset <= pat_preset[idx];
		cmd_req      <= 1'b1;

		waited   = 0;
		ack_seen = 1'b0;
		while (!ack_seen)
		begin
			@(posedge I_clk_25M);
			ack_seen = cmd_ack;
			if (ack_seen)
				check_flag("flash_cs_n", flash_cs_n, 1'b1);     // frame over before ack
			@(negedge I_clk_25M);
			if (read_valid)
			begin
				check_byte("read_data", read_data, exp_val[BYTE_W-1:0] + byte_t'(reads));
				reads++;
			end
			waited++;
			if (waited > TIMEOUT)
				report_timeout("cmd_ack to rise");
		end

		cmd_req <= 1'b0;
		waited   = 0;
		ack_seen = 1'b1;
		while (ack_seen)
		begin
			@(posedge I_clk_25M);
			ack_seen = cmd_ack;
			if (waited == 0)
				check_flag("cmd_ack", ack_seen, 1'b1);          // drops one edge later
			waited++;
			if (waited > TIMEOUT)
				report_timeout("cmd_ack to fall");
		end
		@(negedge I_clk_25M);

		check_count("sclk pulses", sclk_pulses - pulses_before, want_pulses);
		check_count("frames", model_frames - frames_before, 1);
		check_count("read_valid pulses", reads, want_reads);
		check_kind_code(kind, model_op, pat_op[idx]);
		if (kind == CMD_SE || kind == CMD_PP || kind == CMD_READ)
			check_addr("model_addr", model_addr, pat_addr[idx]);
		if (kind == CMD_WRSR)
			check_status("model status", model_wdata[STATUS_W-1:0], exp_val);
		if (kind == CMD_PP)
			for (i = 0; i < PROG_BYTES; i++)
				check_byte("model prog byte",
					model_wdata[BYTE_W*(PROG_BYTES-1-i) +: BYTE_W], exp_val[BYTE_W-1:0]);
	endtask

	initial
	begin
		I_clk_25M    = 1'b0;
		I_rst_n      = 1'b0;
		cmd_req      = 1'b0;
		cmd_kind     = CMD_WREN;
		cmd_addr     = '0;
		status_wr    = '0;
		prog_data    = '0;
		model_preset = '0;
		seed         = 32'h0f978695;
		load_patterns();

		repeat (10) @(negedge I_clk_25M);
		I_rst_n <= 1'b1;
		idle_pulses = sclk_pulses;
		repeat (4) @(negedge I_clk_25M);
		@(posedge I_clk_25M);
		#10;                                     // middle of the high phase
		check_flag("flash_sclk", flash_sclk, 1'b0);
		@(negedge I_clk_25M);
		check_flag("flash_cs_n", flash_cs_n, 1'b1);
		check_flag("cmd_ack", cmd_ack, 1'b0);
		check_flag("read_valid", read_valid, 1'b0);
		check_count("idle sclk pulses", sclk_pulses - idle_pulses, 0);

		for (n = 0; n < pat_kind.size(); n++)
			run_command(n);

		// back-to-back commands picked from the table
		for (n = 0; n < RAND_RUNS; n++)
		begin
			pick = $unsigned($random(seed)) % pat_kind.size();
			run_command(pick);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/flash_model.sv
`default_nettype none

module flash_model
	import flash_pkg::*;
(
	input  wire          sclk,
	input  wire          cs_n,
	input  wire          io0,
	input  wire byte_t   preset,
	output logic         io1,
	output byte_t        op,
	output addr_t        addr,
	output logic [63:0]  wdata,
	output int           frames
);

	timeunit 1ns;
	timeprecision 1ps;

	int    bit_cnt;                          // sclk rising edges in this frame
	int    rd_start;                         // first read bit, -1 if no read phase
	int    rd_pos;
	byte_t rd_byte;

	function automatic bit has_addr(input byte_t code);
		return code == instr_code(CMD_SE) || code == instr_code(CMD_PP) ||
			code == instr_code(CMD_READ);
	endfunction

	initial
	begin
		io1     = 1'b0;
		op      = '0;
		addr    = '0;
		wdata   = '0;
		frames  = 0;
		bit_cnt = 0;
	end

	////////////////////////////////////////
	// frame decode, sclk rising edge
	////////////////////////////////////////
	always @(posedge sclk or negedge cs_n)
	begin
		if (!sclk)
		begin
			bit_cnt = 0;                     // cs_n fell, new frame
			op      = '0;
			addr    = '0;
			wdata   = '0;
		end
		else if (!cs_n)
		begin
			if (bit_cnt < BYTE_W)
				op = {op[BYTE_W-2:0], io0};
			else if (has_addr(op) && bit_cnt < BYTE_W + ADDR_W)
				addr = {addr[ADDR_W-2:0], io0};
			else
				wdata = {wdata[62:0], io0};  // status value or program bytes
			bit_cnt = bit_cnt + 1;
		end
	end

	always @(posedge cs_n)
	begin
		if (bit_cnt > 0)
			frames = frames + 1;
	end

	// read answers launch on the sclk falling edge
	always @(negedge sclk)
	begin
		if (!cs_n)
		begin
			rd_start = -1;
			if (op == instr_code(CMD_RDSR))
				rd_start = BYTE_W;
			else if (op == instr_code(CMD_READ))
				rd_start = BYTE_W + ADDR_W;
			if (rd_start >= 0 && bit_cnt >= rd_start)
			begin
				rd_pos  = bit_cnt - rd_start;
				rd_byte = preset + byte_t'(rd_pos / BYTE_W);     // preset plus offset
				io1     = rd_byte[BYTE_W - 1 - (rd_pos % BYTE_W)];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/flash_driver.sv
`default_nettype none

module flash_driver
	import flash_pkg::*;
#(
	parameter int READ_BYTES = 4,
	parameter int PROG_BYTES = 2
)(
	input  wire            I_clk_25M,
	input  wire            I_rst_n,
	input  wire            cmd_req,
	input  wire cmd_kind_e cmd_kind,
	input  wire addr_t     cmd_addr,
	input  wire status_t   status_wr,
	input  wire byte_t     prog_data,
	output logic           cmd_ack,
	output byte_t          read_data,
	output logic           read_valid,
	output logic           flash_sclk,
	output logic           flash_cs_n,
	output logic           flash_io0,
	input  wire            flash_io1
);

	localparam int RX_CNT_W = $clog2(READ_BYTES + 1);

	logic                sclk_en;
	logic                tx_load;
	logic                tx_shift;
	field_sel_e          tx_sel;
	logic                rx_run;
	logic [RX_CNT_W-1:0] rx_limit;
	logic                rx_done;

	// enable only changes while the clock is low
	assign flash_sclk = I_clk_25M & sclk_en;

	////////////////////////////////////////
	// frame control
	////////////////////////////////////////
	flash_cmd_seq #(
		.READ_BYTES (READ_BYTES),
		.PROG_BYTES (PROG_BYTES)
	) u_cmd_seq (
		.I_clk_25M  (I_clk_25M),
		.I_rst_n    (I_rst_n),
		.cmd_req    (cmd_req),
		.cmd_kind   (cmd_kind),
		.cmd_ack    (cmd_ack),
		.flash_cs_n (flash_cs_n),
		.sclk_en    (sclk_en),
		.tx_load    (tx_load),
		.tx_shift   (tx_shift),
		.tx_sel     (tx_sel),
		.rx_run     (rx_run),
		.rx_limit   (rx_limit),
		.rx_done    (rx_done)
	);

	flash_tx_shifter u_tx_shifter (
		.I_clk_25M (I_clk_25M),
		.I_rst_n   (I_rst_n),
		.tx_load   (tx_load),
		.tx_shift  (tx_shift),
		.tx_sel    (tx_sel),
		.cmd_kind  (cmd_kind),
		.cmd_addr  (cmd_addr),
		.status_wr (status_wr),
		.prog_data (prog_data),
		.flash_io0 (flash_io0)
	);

	flash_rx_deser #(
		.READ_BYTES (READ_BYTES)
	) u_rx_deser (
		.I_clk_25M  (I_clk_25M),
		.I_rst_n    (I_rst_n),
		.rx_run     (rx_run),
		.rx_limit   (rx_limit),
		.flash_io1  (flash_io1),
		.rx_done    (rx_done),
		.read_data  (read_data),
		.read_valid (read_valid)
	);

endmodule

`default_nettype wire

//--- logic/flash_rx_deser.sv
`default_nettype none

module flash_rx_deser
	import flash_pkg::*;
#(
	parameter int READ_BYTES = 4,
	localparam int RX_CNT_W  = $clog2(READ_BYTES + 1)
)(
	input  wire                 I_clk_25M,
	input  wire                 I_rst_n,
	input  wire                 rx_run,
	input  wire [RX_CNT_W-1:0]  rx_limit,
	input  wire                 flash_io1,
	output logic                rx_done,
	output byte_t               read_data,
	output logic                read_valid
);

	logic [2:0]          bit_cnt;
	logic [RX_CNT_W-1:0] byte_cnt;
	logic [RX_CNT_W-1:0] byte_cnt_nxt;
	byte_t               shift_q;
	byte_t               byte_nxt;
	logic                byte_end;
	logic                sampling;

	assign byte_nxt     = {shift_q[BYTE_W-2:0], flash_io1};     // msb first
	assign byte_end     = (bit_cnt == 3'd7);
	assign byte_cnt_nxt = byte_cnt + 1'b1;
	assign sampling     = rx_run && !rx_done;

	////////////////////////////////////////
	// counters and strobes, rising edge
	////////////////////////////////////////
	always_ff @(posedge I_clk_25M)
	begin
		if (!I_rst_n)
		begin
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			rx_done    <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_valid <= 1'b0;                       // single-cycle pulse
			if (!rx_run)
			begin
				bit_cnt  <= '0;
				byte_cnt <= '0;
				rx_done  <= 1'b0;
			end
			else if (sampling)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (byte_end)
				begin
					read_valid <= 1'b1;
					byte_cnt   <= byte_cnt_nxt;
					if (byte_cnt_nxt == rx_limit)
						rx_done <= 1'b1;              // stays up until rx_run falls
				end
			end
		end
	end

	always_ff @(posedge I_clk_25M)
	begin
		if (sampling)
		begin
			shift_q <= byte_nxt;
			if (byte_end)
				read_data <= byte_nxt;
		end
	end

endmodule

`default_nettype wire

//--- logic/flash_cmd_seq.sv
`default_nettype none

module flash_cmd_seq
	import flash_pkg::*;
#(
	parameter int READ_BYTES = 4,
	parameter int PROG_BYTES = 2,
	localparam int RX_CNT_W  = $clog2(READ_BYTES + 1)
)(
	input  wire                 I_clk_25M,
	input  wire                 I_rst_n,
	input  wire                 cmd_req,
	input  wire cmd_kind_e      cmd_kind,
	output logic                cmd_ack,
	output logic                flash_cs_n,
	output logic                sclk_en,
	output logic                tx_load,
	output logic                tx_shift,
	output field_sel_e          tx_sel,
	output logic                rx_run,
	output logic [RX_CNT_W-1:0] rx_limit,
	input  wire                 rx_done
);

	localparam int BIT_CNT_W  = $clog2(ADDR_W);
	localparam int PROG_CNT_W = $clog2(PROG_BYTES + 1);

	seq_state_e            state;
	cmd_kind_e             kind_q;
	logic [BIT_CNT_W-1:0]  bit_cnt;                 // bits left in the field
	logic [PROG_CNT_W-1:0] byte_cnt;                // program bytes sent
	logic                  phase_end;
	logic                  last_prog;

	assign phase_end = (bit_cnt == '0);
	assign last_prog = (byte_cnt == PROG_CNT_W'(PROG_BYTES - 1));

	////////////////////////////////////////
	// shifter strobes
	////////////////////////////////////////
	always_comb
	begin
		tx_load  = 1'b0;
		tx_shift = 1'b0;
		tx_sel   = FIELD_CMD;
		case (state)
			SEQ_IDLE:
				tx_load = cmd_req;                  // opcode goes out first
			SEQ_SEND_CMD:
			begin
				if (!phase_end)
					tx_shift = 1'b1;
				else if (kind_q == CMD_WRSR)
				begin
					tx_load = 1'b1;
					tx_sel  = FIELD_STATUS;
				end
				else if (kind_q == CMD_SE || kind_q == CMD_PP || kind_q == CMD_READ)
				begin
					tx_load = 1'b1;
					tx_sel  = FIELD_ADDR;
				end
			end
			SEQ_SEND_ADDR:
			begin
				if (!phase_end)
					tx_shift = 1'b1;
				else if (kind_q == CMD_PP)
				begin
					tx_load = 1'b1;
					tx_sel  = FIELD_DATA;
				end
			end
			SEQ_SEND_STATUS:
				tx_shift = !phase_end;
			SEQ_WRITE_DATA:
			begin
				if (!phase_end)
					tx_shift = 1'b1;
				else if (!last_prog)
				begin
					tx_load = 1'b1;
					tx_sel  = FIELD_DATA;       // same byte again
				end
			end
			default:
				tx_load = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// frame FSM, falling edge
	////////////////////////////////////////
	always_ff @(negedge I_clk_25M)
	begin
		if (!I_rst_n)
		begin
			state      <= SEQ_IDLE;
			kind_q     <= CMD_WREN;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			flash_cs_n <= 1'b1;
			sclk_en    <= 1'b0;
			cmd_ack    <= 1'b0;
			rx_run     <= 1'b0;
			rx_limit   <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (cmd_req)
					begin
						kind_q     <= cmd_kind;
						state      <= SEQ_SEND_CMD;
						bit_cnt    <= BIT_CNT_W'(BYTE_W - 1);
						flash_cs_n <= 1'b0;
						sclk_en    <= 1'b1;
					end
				end
				SEQ_SEND_CMD:
				begin
					if (!phase_end)
						bit_cnt <= bit_cnt - 1'b1;
					else if (kind_q == CMD_WRSR)
					begin
						state   <= SEQ_SEND_STATUS;
						bit_cnt <= BIT_CNT_W'(STATUS_W - 1);
					end
					else if (kind_q == CMD_SE || kind_q == CMD_PP || kind_q == CMD_READ)
					begin
						state   <= SEQ_SEND_ADDR;
						bit_cnt <= BIT_CNT_W'(ADDR_W - 1);
					end
					else if (kind_q == CMD_RDSR)
					begin
						state    <= SEQ_READ_WAIT;
						rx_run   <= 1'b1;
						rx_limit <= RX_CNT_W'(1);       // one status byte
					end
					else
					begin
						state      <= SEQ_FINISH;       // opcode-only frame
						flash_cs_n <= 1'b1;
						sclk_en    <= 1'b0;
					end
				end
				SEQ_SEND_ADDR:
				begin
					if (!phase_end)
						bit_cnt <= bit_cnt - 1'b1;
					else if (kind_q == CMD_PP)
					begin
						state    <= SEQ_WRITE_DATA;
						bit_cnt  <= BIT_CNT_W'(BYTE_W - 1);
						byte_cnt <= '0;
					end
					else if (kind_q == CMD_READ)
					begin
						state    <= SEQ_READ_WAIT;
						rx_run   <= 1'b1;
						rx_limit <= RX_CNT_W'(READ_BYTES);
					end
					else
					begin
						state      <= SEQ_FINISH;       // sector erase ends here
						flash_cs_n <= 1'b1;
						sclk_en    <= 1'b0;
					end
				end
				SEQ_SEND_STATUS:
				begin
					if (!phase_end)
						bit_cnt <= bit_cnt - 1'b1;
					else
					begin
						state      <= SEQ_FINISH;
						flash_cs_n <= 1'b1;
						sclk_en    <= 1'b0;
					end
				end
				SEQ_WRITE_DATA:
				begin
					if (!phase_end)
						bit_cnt <= bit_cnt - 1'b1;
					else if (!last_prog)
					begin
						bit_cnt  <= BIT_CNT_W'(BYTE_W - 1);
						byte_cnt <= byte_cnt + 1'b1;
					end
					else
					begin
						state      <= SEQ_FINISH;
						flash_cs_n <= 1'b1;
						sclk_en    <= 1'b0;
					end
				end
				SEQ_READ_WAIT:
				begin
					if (rx_done)                        // last byte is in
					begin
						state      <= SEQ_FINISH;
						rx_run     <= 1'b0;
						flash_cs_n <= 1'b1;
						sclk_en    <= 1'b0;
					end
				end
				SEQ_FINISH:
				begin
					if (cmd_req)
						cmd_ack <= 1'b1;                // hold until req drops
					else
					begin
						cmd_ack <= 1'b0;
						state   <= SEQ_IDLE;
					end
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/flash_tx_shifter.sv
`default_nettype none

module flash_tx_shifter
	import flash_pkg::*;
(
	input  wire             I_clk_25M,
	input  wire             I_rst_n,
	input  wire             tx_load,
	input  wire             tx_shift,
	input  wire field_sel_e tx_sel,
	input  wire cmd_kind_e  cmd_kind,
	input  wire addr_t      cmd_addr,
	input  wire status_t    status_wr,
	input  wire byte_t      prog_data,
	output logic            flash_io0
);

	addr_t   shift_q;                    // msb drives io0
	addr_t   addr_q;
	status_t status_q;
	addr_t   load_val;

	// every field sits left-aligned in the 24-bit register
	always_comb
	begin
		case (tx_sel)
			FIELD_CMD:    load_val = {instr_code(cmd_kind), {(ADDR_W-BYTE_W){1'b0}}};
			FIELD_ADDR:   load_val = addr_q;
			FIELD_STATUS: load_val = {status_q, {(ADDR_W-STATUS_W){1'b0}}};
			default:      load_val = {prog_data, {(ADDR_W-BYTE_W){1'b0}}};
		endcase
	end

	// address and status are captured with the opcode load
	always_ff @(negedge I_clk_25M)
	begin
		if (tx_load && tx_sel == FIELD_CMD)
		begin
			addr_q   <= cmd_addr;
			status_q <= status_wr;
		end
	end

	always_ff @(negedge I_clk_25M)
	begin
		if (!I_rst_n)
			shift_q <= '0;
		else if (tx_load)
			shift_q <= load_val;
		else if (tx_shift)
			shift_q <= shift_q << 1;                // next bit to the top
		else
			shift_q <= '0;                          // io0 rests low
	end

	assign flash_io0 = shift_q[ADDR_W-1];

endmodule

`default_nettype wire

//--- logic/flash_pkg.sv
`default_nettype none

package flash_pkg;

	////////////////////////////////////////
	// field widths
	////////////////////////////////////////
	localparam int ADDR_W   = 24;        // flash byte address
	localparam int STATUS_W = 16;        // status register pair
	localparam int BYTE_W   = 8;

	typedef logic [BYTE_W-1:0]   byte_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [STATUS_W-1:0] status_t;

	////////////////////////////////////////
	// command kinds and FSM states
	////////////////////////////////////////
	typedef enum logic [2:0] {
		CMD_WREN  = 3'd0,                // write enable
		CMD_WRDI  = 3'd1,                // write disable
		CMD_RDSR  = 3'd2,                // read status, one byte back
		CMD_WRSR  = 3'd3,                // write status, 16 bits out
		CMD_SE    = 3'd4,                // sector erase
		CMD_PP    = 3'd5,                // page program, single line
		CMD_READ  = 3'd6                 // read data, single line
	} cmd_kind_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SEND_CMD,
		SEQ_SEND_ADDR,
		SEQ_SEND_STATUS,
		SEQ_WRITE_DATA,
		SEQ_READ_WAIT,
		SEQ_FINISH
	} seq_state_e;

	typedef enum logic [1:0] {
		FIELD_CMD,
		FIELD_ADDR,
		FIELD_STATUS,
		FIELD_DATA
	} field_sel_e;

	// instruction code for each command kind
	function automatic byte_t instr_code(input cmd_kind_e kind);
		case (kind)
			CMD_WREN: return 8'h06;
			CMD_WRDI: return 8'h04;
			CMD_RDSR: return 8'h05;
			CMD_WRSR: return 8'h01;
			CMD_SE:   return 8'h20;
			CMD_PP:   return 8'h02;
			CMD_READ: return 8'h03;
			default:  return 8'h00;
		endcase
	endfunction

endpackage

`default_nettype wire
